//--- ifu_pkg.sv
/*
 * RV32 fetch unit shared definitions
 * Memory response codes, word classification and the fetch bundles
 */
package ifu_pkg;

    // Defaults for the top-level parameters
    localparam int unsigned IFU_XLEN        = 32;
    localparam int unsigned IFU_Q_SIZE_WORD = 4;    // 8 halfwords
    localparam int unsigned IFU_TXN_CNT_W   = 3;    // Up to 7 reads in flight

    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,    // No response this cycle
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // One memory word, seen whole or as two 16-bit parcels
    typedef union packed {
        logic [31:0]          word;
        logic [1:0][15:0]     parcel;   // [0] is the lower address
    } fetch_word_u;

    // Named <upper parcel>_<lower parcel>
    typedef enum logic [2:0] {
        INSTR_NONE,
        INSTR_RVI_HI_RVI_LO,        // Whole RVI
        INSTR_RVC_RVC,
        INSTR_RVI_LO_RVC,
        INSTR_RVC_RVI_HI,
        INSTR_RVI_LO_RVI_HI,
        INSTR_RVC_NV,               // Lower parcel dropped, unaligned PC
        INSTR_RVI_LO_NV
    } instr_kind_e;

    typedef enum logic [1:0] {
        Q_WR_NONE,
        Q_WR_FULL,                  // Both parcels
        Q_WR_HI                     // Upper parcel only
    } q_wr_e;

    typedef struct packed {
        logic                  req;     // Redirect pulse
        logic [IFU_XLEN-1:0]   pc;
    } new_pc_t;

    typedef struct packed {
        logic                  req;
        logic [IFU_XLEN-1:0]   addr;    // Word aligned
    } imem_req_t;

    typedef struct packed {
        mem_resp_e             resp;
        fetch_word_u           rdata;
    } imem_resp_t;

    typedef struct packed {
        logic                  vd;      // Response kept
        logic                  er;      // Response is an error
        logic                  er_stop; // Kept error, fetch must stop
    } resp_fire_t;

    typedef struct packed {
        q_wr_e                 size;
        fetch_word_u           data;
        logic                  err;
    } q_wr_t;

    typedef struct packed {
        logic                  vd;
        logic [31:0]           instr;
        logic                  imem_err;
        logic                  err_rvi_hi;  // Fault in upper half of RVI
    } idu_out_t;

endpackage : ifu_pkg

//--- ifu_fetch_ctrl.sv
/*
 * Fetch control: idle/fetch FSM, word address register
 * and instruction memory request generation
 */
`timescale 1ns/1ps

module ifu_fetch_ctrl
    import ifu_pkg::*;
#(
    parameter int unsigned XLEN      = IFU_XLEN,
    parameter int unsigned TXN_CNT_W = IFU_TXN_CNT_W
) (
    input  logic       clk,
    input  logic       rst_n,
    input  new_pc_t    new_pc_i,
    input  logic       stop_fetch_i,
    input  logic       imem_ack_i,
    input  logic       er_stop_i,         // Kept error response
    input  logic       pnd_full_i,        // Pending counter saturated
    input  logic       has_free_slots_i,  // Queue room beyond reads in flight
    output imem_req_t  imem_req_o,
    output logic       hs_done_o
);

    typedef enum logic {
        FSM_IDLE,
        FSM_FETCH
    } fsm_e;

    fsm_e              fsm_ff;
    fsm_e              fsm_next;
    logic              fetch_req;
    logic              stop_req;
    logic              addr_upd;
    logic [XLEN-1:2]   addr_ff;
    logic [XLEN-1:2]   addr_next;

    // Struct widths are fixed by the package
    if (XLEN != IFU_XLEN || TXN_CNT_W < 2) begin : g_param_chk
        $error("ifu_fetch_ctrl: unsupported XLEN or TXN_CNT_W");
    end

    // ------------------------------
    // FSM
    // ------------------------------
    assign fetch_req = new_pc_i.req & ~stop_fetch_i;
    assign stop_req  = stop_fetch_i | (er_stop_i & ~new_pc_i.req);   // Redirect overrides error

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm_ff <= FSM_IDLE;
        end else begin
            fsm_ff <= fsm_next;
        end
    end

    always_comb begin
        case (fsm_ff)
            FSM_IDLE:  fsm_next = fetch_req ? FSM_FETCH : FSM_IDLE;
            FSM_FETCH: fsm_next = stop_req  ? FSM_IDLE  : FSM_FETCH;
            default:   fsm_next = FSM_IDLE;
        endcase
    end

    // ------------------------------
    // Word address register
    // ------------------------------
    assign addr_upd  = hs_done_o | new_pc_i.req;
    assign addr_next = new_pc_i.req ? new_pc_i.pc[XLEN-1:2] + (XLEN-2)'(hs_done_o)
                                    : addr_ff + 1'b1;   // Only reached on a handshake

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_ff <= '0;
        end else if (addr_upd) begin
            addr_ff <= addr_next;
        end
    end

    // Request goes out in the redirect cycle itself
    assign imem_req_o.req  = (new_pc_i.req & ~pnd_full_i & ~stop_fetch_i)
                           | ((fsm_ff == FSM_FETCH) & ~pnd_full_i & has_free_slots_i);
    assign imem_req_o.addr = new_pc_i.req ? {new_pc_i.pc[XLEN-1:2], 2'b00}
                                          : {addr_ff, 2'b00};
    assign hs_done_o       = imem_req_o.req & imem_ack_i;

    // Back-to-back reads walk through memory one word at a time
    a_addr_step : assert property (@(posedge clk) disable iff (!rst_n)
        hs_done_o |=> (!imem_req_o.req || new_pc_i.req
                       || (imem_req_o.addr == $past(imem_req_o.addr) + XLEN'(4))))
        else $error("fetch: request address skipped a word");

    a_stop_idle : assert property (@(posedge clk) disable iff (!rst_n)
        stop_fetch_i |=> (fsm_ff == FSM_IDLE))
        else $error("fetch: FSM not idle after stop");

endmodule : ifu_fetch_ctrl

//--- ifu_imem_txn.sv
/*
 * Memory transaction tracking: response classification,
 * pending reads counter and discard counter
 */
`timescale 1ns/1ps

module ifu_imem_txn
    import ifu_pkg::*;
#(
    parameter int unsigned TXN_CNT_W = IFU_TXN_CNT_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_resp_e             imem_resp_i,
    input  logic                  hs_done_i,
    input  logic                  new_pc_req_i,
    output resp_fire_t            fire_o,
    output logic                  pnd_full_o,
    output logic [TXN_CNT_W-1:0]  vd_pnd_cnt_o   // Reads in flight that will be kept
);

    logic                  resp_ok;
    logic                  resp_er;
    logic                  resp_received;
    logic                  discard_req;
    logic [TXN_CNT_W-1:0]  pnd_cnt;
    logic [TXN_CNT_W-1:0]  pnd_cnt_next;
    logic                  discard_upd;
    logic [TXN_CNT_W-1:0]  discard_cnt;
    logic [TXN_CNT_W-1:0]  discard_cnt_next;

    // ------------------------------
    // Response classification
    // ------------------------------
    assign resp_ok       = (imem_resp_i == MEM_RESP_RDY_OK);
    assign resp_er       = (imem_resp_i == MEM_RESP_RDY_ER);
    assign resp_received = resp_ok | resp_er;
    assign discard_req   = |discard_cnt;     // Still draining a stale stream

    assign fire_o.vd      = resp_received & ~discard_req;
    assign fire_o.er      = resp_er;
    assign fire_o.er_stop = resp_er & ~discard_req;

    // ------------------------------
    // Pending reads
    // ------------------------------
    // Handshake and response in one cycle cancel out
    assign pnd_cnt_next = pnd_cnt + TXN_CNT_W'(hs_done_i) - TXN_CNT_W'(resp_received);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pnd_cnt <= '0;
        end else begin
            pnd_cnt <= pnd_cnt_next;
        end
    end

    assign pnd_full_o = &pnd_cnt;

    // ------------------------------
    // Discard counter
    // ------------------------------
    // On a redirect the read accepted this cycle already belongs to the new stream
    assign discard_upd      = new_pc_req_i | resp_er | (resp_ok & discard_req);
    assign discard_cnt_next = new_pc_req_i   ? pnd_cnt_next - TXN_CNT_W'(hs_done_i)
                            : fire_o.er_stop ? pnd_cnt_next      // Drop whatever follows the fault
                                             : discard_cnt - 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            discard_cnt <= '0;
        end else if (discard_upd) begin
            discard_cnt <= discard_cnt_next;
        end
    end

    assign vd_pnd_cnt_o = pnd_cnt - discard_cnt;

    a_discard_range : assert property (@(posedge clk) disable iff (!rst_n)
        discard_cnt <= pnd_cnt)
        else $error("txn: discard counter above pending count");

    // Every response needs a read still in flight
    a_pnd_underflow : assert property (@(posedge clk) disable iff (!rst_n)
        resp_received |-> (pnd_cnt != '0))
        else $error("txn: response with no read pending");

endmodule : ifu_imem_txn

//--- ifu_instr_align.sv
/*
 * Instruction alignment: classifies each kept memory word
 * into parcels and builds the queue write command
 */
`timescale 1ns/1ps

module ifu_instr_align
    import ifu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  new_pc_t      new_pc_i,
    input  resp_fire_t   fire_i,
    input  fetch_word_u  rdata_i,
    output q_wr_t        q_wr_o
);

    logic         new_pc_unaligned_ff;
    logic         new_pc_unaligned_upd;
    logic         hi_rvi_lo_ff;
    logic         hi_rvi_lo_next;
    logic         hi_is_rvi;
    logic         lo_is_rvi;
    logic         resp_ok;
    instr_kind_e  instr_kind;

    // ------------------------------
    // Unaligned new PC flag
    // ------------------------------
    // Set by a redirect to PC+2, cleared by the first kept word
    assign new_pc_unaligned_upd = new_pc_i.req | fire_i.vd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_pc_unaligned_ff <= 1'b0;
        end else if (new_pc_unaligned_upd) begin
            new_pc_unaligned_ff <= new_pc_i.req ? new_pc_i.pc[1] : 1'b0;
        end
    end

    // ------------------------------
    // Parcel type decoder
    // ------------------------------
    assign hi_is_rvi = &rdata_i.parcel[1][1:0];
    assign lo_is_rvi = &rdata_i.parcel[0][1:0];
    assign resp_ok   = fire_i.vd & ~fire_i.er;

    always_comb begin
        instr_kind = INSTR_NONE;
        if (resp_ok) begin
            if (new_pc_unaligned_ff) begin
                instr_kind = hi_is_rvi ? INSTR_RVI_LO_NV : INSTR_RVC_NV;
            end else if (hi_rvi_lo_ff) begin
                // Lower parcel completes the previous RVI
                instr_kind = hi_is_rvi ? INSTR_RVI_LO_RVI_HI : INSTR_RVC_RVI_HI;
            end else begin
                case ({hi_is_rvi, lo_is_rvi})
                    2'b00:   instr_kind = INSTR_RVC_RVC;
                    2'b10:   instr_kind = INSTR_RVI_LO_RVC;
                    default: instr_kind = INSTR_RVI_HI_RVI_LO;  // Upper bits are RVI payload
                endcase
            end
        end
    end

    // Word ends in the lower half of an RVI
    assign hi_rvi_lo_next = (instr_kind == INSTR_RVI_LO_NV)
                          | (instr_kind == INSTR_RVI_LO_RVI_HI)
                          | (instr_kind == INSTR_RVI_LO_RVC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi_rvi_lo_ff <= 1'b0;
        end else if (new_pc_i.req) begin
            hi_rvi_lo_ff <= 1'b0;
        end else if (fire_i.vd) begin
            hi_rvi_lo_ff <= hi_rvi_lo_next;   // Error word clears it too
        end
    end

    // ------------------------------
    // Queue write command
    // ------------------------------
    always_comb begin
        q_wr_o.size = Q_WR_NONE;
        if (fire_i.vd) begin
            if (fire_i.er) begin
                q_wr_o.size = Q_WR_FULL;      // Both halves carry the fault
            end else begin
                case (instr_kind)
                    INSTR_NONE:      q_wr_o.size = Q_WR_NONE;
                    INSTR_RVC_NV,
                    INSTR_RVI_LO_NV: q_wr_o.size = Q_WR_HI;
                    default:         q_wr_o.size = Q_WR_FULL;
                endcase
            end
        end
    end

    assign q_wr_o.data = rdata_i;
    assign q_wr_o.err  = fire_i.er;

endmodule : ifu_instr_align

//--- ifu_queue.sv
/*
 * Halfword instruction queue with per-parcel error bits,
 * free space status and the decoder-side instruction output
 */
`timescale 1ns/1ps

module ifu_queue
    import ifu_pkg::*;
#(
    parameter int unsigned Q_SIZE_WORD = IFU_Q_SIZE_WORD,
    parameter int unsigned TXN_CNT_W   = IFU_TXN_CNT_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  q_wr_t                 q_wr_i,
    input  logic                  new_pc_req_i,
    input  logic                  stop_fetch_i,
    input  logic [TXN_CNT_W-1:0]  vd_pnd_cnt_i,
    input  logic                  idu_rdy_i,
    output logic                  has_free_slots_o,
    output idu_out_t              idu_o
);

    localparam int unsigned Q_SIZE_HALF = Q_SIZE_WORD * 2;
    localparam int unsigned ADR_W       = $clog2(Q_SIZE_HALF);
    localparam int unsigned PTR_W       = ADR_W + 1;     // Extra bit tells full from empty
    localparam int unsigned FREE_H_W    = $clog2(Q_SIZE_HALF + 1);
    localparam int unsigned FREE_W_W    = $clog2(Q_SIZE_WORD + 1);

    logic [15:0]            q_data [Q_SIZE_HALF];
    logic [Q_SIZE_HALF-1:0] q_err;
    logic [PTR_W-1:0]       q_wptr;
    logic [PTR_W-1:0]       q_wptr_next;
    logic [PTR_W-1:0]       q_rptr;
    logic [PTR_W-1:0]       q_rptr_next;
    logic [ADR_W-1:0]       wadr0;
    logic [ADR_W-1:0]       wadr1;
    logic [ADR_W-1:0]       radr0;
    logic [ADR_W-1:0]       radr1;
    logic                   q_flush;
    logic                   q_wr_en;
    logic                   q_wr_full;
    logic                   q_rd_vd;
    logic                   q_rd_hword;
    logic                   q_is_empty;
    logic                   q_has_1_ocpd_hw;
    logic                   head_is_rvi;
    logic                   err_head;
    logic                   err_next;
    logic [FREE_H_W-1:0]    q_ocpd_h;
    logic [FREE_H_W-1:0]    q_free_h_next;
    logic [FREE_W_W-1:0]    q_free_w_next;

    // ------------------------------
    // Pointers
    // ------------------------------
    assign q_flush    = new_pc_req_i | stop_fetch_i;
    assign q_wr_full  = (q_wr_i.size == Q_WR_FULL);
    assign q_wr_en    = (q_wr_i.size != Q_WR_NONE) & ~q_flush;
    assign q_rd_vd    = ~q_is_empty & idu_o.vd & idu_rdy_i;
    assign q_rd_hword = ~head_is_rvi | err_head;     // Faulty head leaves alone

    assign q_wptr_next = q_flush ? '0
                       : q_wr_en ? q_wptr + (q_wr_full ? PTR_W'(2) : PTR_W'(1))
                                 : q_wptr;
    assign q_rptr_next = q_flush ? '0
                       : q_rd_vd ? q_rptr + (q_rd_hword ? PTR_W'(1) : PTR_W'(2))
                                 : q_rptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_wptr <= '0;
            q_rptr <= '0;
        end else begin
            q_wptr <= q_wptr_next;
            q_rptr <= q_rptr_next;
        end
    end

    // ------------------------------
    // Storage
    // ------------------------------
    assign wadr0 = ADR_W'(q_wptr);
    assign wadr1 = ADR_W'(q_wptr + 1'b1);
    assign radr0 = ADR_W'(q_rptr);
    assign radr1 = ADR_W'(q_rptr + 1'b1);

    always_ff @(posedge clk) begin
        if (q_wr_en) begin
            if (q_wr_full) begin
                q_data[wadr0] <= q_wr_i.data.parcel[0];
                q_err[wadr0]  <= q_wr_i.err;
                q_data[wadr1] <= q_wr_i.data.parcel[1];
                q_err[wadr1]  <= q_wr_i.err;
            end else begin
                q_data[wadr0] <= q_wr_i.data.parcel[1];   // Upper parcel only
                q_err[wadr0]  <= q_wr_i.err;
            end
        end
    end

    assign err_head    = q_err[radr0];
    assign err_next    = q_err[radr1];
    assign head_is_rvi = &q_data[radr0][1:0];

    // ------------------------------
    // Status
    // ------------------------------
    assign q_is_empty      = (q_rptr == q_wptr);
    assign q_ocpd_h        = FREE_H_W'(q_wptr - q_rptr);
    assign q_has_1_ocpd_hw = (q_ocpd_h == FREE_H_W'(1));
    assign q_free_h_next   = FREE_H_W'(Q_SIZE_HALF - (q_wptr - q_rptr_next));
    assign q_free_w_next   = FREE_W_W'(q_free_h_next >> 1);

    // Room for every kept read already in flight plus one more
    assign has_free_slots_o = (q_free_w_next > vd_pnd_cnt_i);

    // Decoder side
    always_comb begin
        idu_o.vd         = 1'b0;
        idu_o.imem_err   = 1'b0;
        idu_o.err_rvi_hi = 1'b0;
        idu_o.instr      = head_is_rvi ? {q_data[radr1], q_data[radr0]}
                                       : {16'h0000, q_data[radr0]};
        if (!q_is_empty) begin
            if (q_has_1_ocpd_hw) begin
                idu_o.vd       = ~head_is_rvi | err_head;   // Lone RVI half waits
                idu_o.imem_err = err_head;
            end else begin
                idu_o.vd         = 1'b1;
                idu_o.imem_err   = err_head | (head_is_rvi & err_next);
                idu_o.err_rvi_hi = ~err_head & head_is_rvi & err_next;
            end
        end
    end

    // Fetch back-pressure must keep the queue from overflowing
    a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
        (q_ocpd_h >= FREE_H_W'(Q_SIZE_HALF - 1)) |->
        ((q_ocpd_h == FREE_H_W'(Q_SIZE_HALF - 1)) ? (q_wr_i.size != Q_WR_FULL)
                                                  : (q_wr_i.size == Q_WR_NONE)))
        else $error("queue: write would overflow");

endmodule : ifu_queue

//--- ifu_top.sv
/*
 * RV32 instruction fetch unit top level
 */
`timescale 1ns/1ps

module ifu_top
    import ifu_pkg::*;
#(
    parameter int unsigned XLEN        = IFU_XLEN,
    parameter int unsigned Q_SIZE_WORD = IFU_Q_SIZE_WORD,
    parameter int unsigned TXN_CNT_W   = IFU_TXN_CNT_W
) (
    input  logic        clk,
    input  logic        rst_n,
    input  new_pc_t     new_pc_i,       // From execute unit
    input  logic        stop_fetch_i,
    input  logic        imem_ack_i,
    input  imem_resp_t  imem_resp_i,
    output imem_req_t   imem_req_o,
    input  logic        idu_rdy_i,
    output idu_out_t    idu_o
);

    logic                  hs_done;
    resp_fire_t            fire;
    logic                  pnd_full;
    logic [TXN_CNT_W-1:0]  vd_pnd_cnt;
    q_wr_t                 q_wr;
    logic                  has_free_slots;

    ifu_fetch_ctrl #(
        .XLEN      (XLEN),
        .TXN_CNT_W (TXN_CNT_W)
    ) u_fetch_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .new_pc_i         (new_pc_i),
        .stop_fetch_i     (stop_fetch_i),
        .imem_ack_i       (imem_ack_i),
        .er_stop_i        (fire.er_stop),
        .pnd_full_i       (pnd_full),
        .has_free_slots_i (has_free_slots),
        .imem_req_o       (imem_req_o),
        .hs_done_o        (hs_done)
    );

    ifu_imem_txn #(
        .TXN_CNT_W (TXN_CNT_W)
    ) u_imem_txn (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_resp_i  (imem_resp_i.resp),
        .hs_done_i    (hs_done),
        .new_pc_req_i (new_pc_i.req),
        .fire_o       (fire),
        .pnd_full_o   (pnd_full),
        .vd_pnd_cnt_o (vd_pnd_cnt)
    );

    ifu_instr_align u_instr_align (
        .clk      (clk),
        .rst_n    (rst_n),
        .new_pc_i (new_pc_i),
        .fire_i   (fire),
        .rdata_i  (imem_resp_i.rdata),
        .q_wr_o   (q_wr)
    );

    ifu_queue #(
        .Q_SIZE_WORD (Q_SIZE_WORD),
        .TXN_CNT_W   (TXN_CNT_W)
    ) u_queue (
        .clk              (clk),
        .rst_n            (rst_n),
        .q_wr_i           (q_wr),
        .new_pc_req_i     (new_pc_i.req),
        .stop_fetch_i     (stop_fetch_i),
        .vd_pnd_cnt_i     (vd_pnd_cnt),
        .idu_rdy_i        (idu_rdy_i),
        .has_free_slots_o (has_free_slots),
        .idu_o            (idu_o)
    );

endmodule : ifu_top

//--- tb_ifu_top.sv
/*
 * Directed testbench for the RV32 fetch unit
 * Memory model with error injection, decoder-side monitor and checking tasks
 */
`timescale 1ns/1ps

module tb_ifu_top
    import ifu_pkg::*;
;

    localparam int MEM_WORDS      = 256;              // 1 KB, aliased over the address space
    localparam int Q_WORDS        = IFU_Q_SIZE_WORD;
    localparam int TEST_CYCLES    = 600;              // Worst directed test incl. flush
    localparam int TIMEOUT_CYCLES = 6 * TEST_CYCLES + 400;

    logic        clk = 1'b0;
    logic        rst_n;
    new_pc_t     new_pc;
    logic        stop_fetch;
    logic        imem_ack;
    imem_resp_t  imem_resp;
    imem_req_t   imem_req;
    logic        idu_rdy;
    idu_out_t    idu;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] rnd_state;
    logic [31:0] err_addr;        // Word that answers with an error
    logic        hs_seen;
    logic [31:0] hs_addr;
    logic [1:0]  pipe_vd;         // Two-stage response delay
    logic [31:0] pipe_addr [2];
    idu_out_t    obs [$];         // Instructions taken by the decoder
    logic [31:0] req_log [$];     // Completed request addresses
    int          n_checks;
    int          n_errors;
    int          cycle_cnt;

    always #4 clk = ~clk;

    ifu_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc_i     (new_pc),
        .stop_fetch_i (stop_fetch),
        .imem_ack_i   (imem_ack),
        .imem_resp_i  (imem_resp),
        .imem_req_o   (imem_req),
        .idu_rdy_i    (idu_rdy),
        .idu_o        (idu)
    );

    // ------------------------------
    // Memory model and monitor
    // ------------------------------
    always @(negedge clk) begin
        hs_seen = rst_n & imem_req.req & imem_ack;   // Stable mid-cycle
        hs_addr = imem_req.addr;
        if (hs_seen) req_log.push_back(hs_addr);
        if (rst_n && idu.vd && idu_rdy) obs.push_back(idu);
    end

    always @(posedge clk) begin
        #1;
        pipe_vd      = {pipe_vd[0], hs_seen};
        pipe_addr[1] = pipe_addr[0];
        pipe_addr[0] = hs_addr;
        if (pipe_vd[1]) begin
            imem_resp.resp       = (pipe_addr[1] == err_addr) ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
            imem_resp.rdata.word = mem[pipe_addr[1][9:2]];
        end else begin
            imem_resp.resp       = MEM_RESP_NOTRDY;
            imem_resp.rdata.word = '0;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: no progress after %0d cycles", cycle_cnt);
            $display("checks: %0d, errors: %0d", n_checks, n_errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rnd_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rnd_state = x;
        return x;
    endfunction

    function automatic logic [15:0] hw_at(input logic [31:0] a);
        logic [31:0] w;
        w = mem[a[9:2]];
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    // Expected split: low bits 11 take two parcels, else one
    function automatic logic [31:0] instr_at(input logic [31:0] a);
        logic [15:0] lo;
        lo = hw_at(a);
        if (lo[1:0] == 2'b11) begin
            return {hw_at(a + 2), lo};
        end
        return {16'h0000, lo};
    endfunction

    task automatic set_hw(input int h, input logic [15:0] v);
        int idx;
        idx = h % (2 * MEM_WORDS);
        if (idx % 2) mem[idx / 2][31:16] = v;
        else         mem[idx / 2][15:0]  = v;
    endtask

    // Parcel stream, RVI only or mixed, RVIs may straddle words
    task automatic fill_mem(input logic rvi_only);
        int          h;
        logic [31:0] r;
        h = 0;
        while (h < 2 * MEM_WORDS) begin
            r = next_rand();
            if (rvi_only || r[20]) begin
                set_hw(h, {r[15:2], 2'b11});
                set_hw(h + 1, r[31:16]);     // Payload only
                h += 2;
            end else begin
                set_hw(h, {r[15:2], r[17] ? 2'b10 : {1'b0, r[16]}});
                h += 1;
            end
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        n_checks++;
        assert (cond === 1'b1) else begin
            n_errors++;
            $display("%s", what);
        end
    endtask

    // Stop fetch long enough for all reads to drain, then clear logs
    task automatic flush_fetch();
        stop_fetch = 1'b1;
        idu_rdy    = 1'b1;
        repeat (4) step();
        stop_fetch = 1'b0;
        step();
        obs.delete();
        req_log.delete();
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        new_pc.req = 1'b1;
        new_pc.pc  = pc;
        step();
        new_pc.req = 1'b0;
    endtask

    task automatic wait_obs(input int n);
        while (obs.size() < n) step();
    endtask

    // Walk memory from pc one instruction at a time
    task automatic check_stream(input logic [31:0] pc, input int n);
        logic [31:0] a;
        logic [31:0] exp;
        int          i;
        a = pc;
        wait_obs(n);
        for (i = 0; i < n; i++) begin
            exp = instr_at(a);
            a   = a + ((exp[1:0] == 2'b11) ? 4 : 2);
            compare_value("idu_o.instr", obs[i].instr, exp);
            compare_value("idu_o.imem_err", obs[i].imem_err, 0);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic aligned_rvi_stream();
        int i;
        fill_mem(1'b1);
        flush_fetch();
        redirect_to(32'h0000_0100);
        check_stream(32'h0000_0100, 16);
        for (i = 0; i < 8; i++) begin
            compare_value("imem_req_o.addr", req_log[i], 32'h0000_0100 + 4 * i);
        end
    endtask

    task automatic mixed_parcel_stream();
        fill_mem(1'b0);
        flush_fetch();
        redirect_to(32'h0000_0040);
        check_stream(32'h0000_0040, 40);
    endtask

    task automatic unaligned_redirect();
        flush_fetch();
        redirect_to(32'h0000_0182);    // Lower parcel of first word dropped
        check_stream(32'h0000_0182, 24);
    endtask

    task automatic redirect_with_pending();
        flush_fetch();
        redirect_to(32'h0000_0040);
        step();                        // Reads to the old stream still in flight
        redirect_to(32'h0000_0200);
        check_stream(32'h0000_0200, 16);
    endtask

    task automatic memory_error();
        int          n;
        logic [31:0] r;
        fill_mem(1'b1);
        err_addr = 32'h0000_0108;      // Third word of the stream
        flush_fetch();
        redirect_to(32'h0000_0100);
        check_stream(32'h0000_0100, 2);
        wait_obs(3);
        compare_value("idu_o.imem_err", obs[2].imem_err, 1);
        compare_value("idu_o.err_rvi_hi", obs[2].err_rvi_hi, 0);
        n = req_log.size();
        repeat (20) step();
        expect_true(req_log.size() == n, "request issued after a memory error");

        // RVC then an RVI whose upper half sits in the faulty word
        r = next_rand();
        mem[32'h0000_0300 >> 2] = {r[31:18], 2'b11, r[15:2], 2'b01};
        err_addr = 32'h0000_0304;
        flush_fetch();
        redirect_to(32'h0000_0300);
        check_stream(32'h0000_0300, 1);
        wait_obs(2);
        compare_value("idu_o.imem_err", obs[1].imem_err, 1);
        compare_value("idu_o.err_rvi_hi", obs[1].err_rvi_hi, 1);
        err_addr = '1;
    endtask

    task automatic back_pressure();
        int          n_mid;
        int          n_end;
        idu_out_t    head_mid;
        idu_out_t    head_end;
        logic [31:0] exp_head;
        fill_mem(1'b0);
        exp_head = instr_at(32'h0000_0080);
        flush_fetch();
        idu_rdy = 1'b0;
        redirect_to(32'h0000_0080);
        repeat (19) step();
        @(negedge clk);
        head_mid = idu;
        n_mid    = req_log.size();
        step();
        repeat (20) step();
        @(negedge clk);
        head_end = idu;
        n_end    = req_log.size();
        expect_true(head_mid.vd, "no instruction at the head during the stall");
        expect_true(head_end.vd, "head instruction lost while the decoder stalled");
        compare_value("idu_o.instr", head_mid.instr, exp_head);
        compare_value("idu_o.instr", head_end.instr, exp_head);     // Held while not ready
        compare_value("idu_o.imem_err", head_end.imem_err, 0);
        expect_true(n_end == n_mid, "requests kept going while the decoder stalled");
        expect_true(n_end <= Q_WORDS, "more reads issued than the queue can hold");
        step();
        idu_rdy = 1'b1;
        check_stream(32'h0000_0080, 40);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rst_n      = 1'b0;
        new_pc     = '0;
        stop_fetch = 1'b0;
        imem_ack   = 1'b1;         // Memory always accepts
        imem_resp  = '0;
        idu_rdy    = 1'b1;
        rnd_state  = 32'd89;
        err_addr   = '1;
        hs_seen    = 1'b0;
        hs_addr    = '0;
        pipe_vd    = '0;
        n_checks   = 0;
        n_errors   = 0;
        cycle_cnt  = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();

        aligned_rvi_stream();
        mixed_parcel_stream();
        unaligned_redirect();
        redirect_with_pending();
        memory_error();
        back_pressure();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_ifu_top

//--- sim.f
ifu_pkg.sv
ifu_fetch_ctrl.sv
ifu_imem_txn.sv
ifu_instr_align.sv
ifu_queue.sv
ifu_top.sv
tb_ifu_top.sv

//--- Bender.yml
package:
  name: ifu

sources:
  - ifu_pkg.sv
  - ifu_fetch_ctrl.sv
  - ifu_imem_txn.sv
  - ifu_instr_align.sv
  - ifu_queue.sv
  - ifu_top.sv
  - target: simulation
    files:
      - tb_ifu_top.sv
